//--- rtl/issue_pkg.sv
`default_nettype none

package issue_pkg;

  localparam int reg_addr_w = 5;
  localparam int reg_count  = 32;
  localparam int xlen       = 32;
  localparam int csr_addr_w = 12;

  // Operation class as seen by the issue logic
  typedef enum logic [3:0] {
    op_none,
    op_alu,
    op_load,
    op_store,
    op_jump,
    op_fence,
    op_csr_read,
    op_csr_write,
    op_div,
    op_fpu
  } op_class_t;

endpackage

`default_nettype wire

//--- rtl/csr_pkg.sv
`default_nettype none

package csr_pkg;

  localparam logic [issue_pkg::csr_addr_w-1:0] csr_fflags   = 12'h001;
  localparam logic [issue_pkg::csr_addr_w-1:0] csr_frm      = 12'h002;
  localparam logic [issue_pkg::csr_addr_w-1:0] csr_fcsr     = 12'h003;
  localparam logic [issue_pkg::csr_addr_w-1:0] csr_mstatus  = 12'h300;
  localparam logic [issue_pkg::csr_addr_w-1:0] csr_mscratch = 12'h340;

  localparam int fs_lsb   = 13;  // mstatus.fs at 14:13
  localparam int fflags_w = 5;

  typedef enum logic [1:0] {
    fs_off,
    fs_initial,
    fs_clean,
    fs_dirty
  } fs_state_t;

  localparam int rm_w = 3;
  localparam logic [rm_w-1:0] rm_dynamic = 3'd7;  // Take rounding mode from frm

endpackage

`default_nettype wire

//--- rtl/pair_check.sv
`timescale 1ns/100ps
`default_nettype none

module pair_check (
  input  issue_pkg::op_class_t             s0_class,
  input  issue_pkg::op_class_t             s1_class,
  input  logic                             s0_wren,
  input  logic                             s1_rden1,
  input  logic                             s1_rden2,
  input  logic [issue_pkg::reg_addr_w-1:0] s0_waddr,
  input  logic [issue_pkg::reg_addr_w-1:0] s1_raddr1,
  input  logic [issue_pkg::reg_addr_w-1:0] s1_raddr2,
  output logic                             pair_ok
);
  import issue_pkg::*;

  logic raw_dep;
  logic mem_pair;
  logic special;

  function automatic logic is_mem(input op_class_t c);
    return c == op_load || c == op_store;
  endfunction

  // Classes that need the single special unit
  function automatic logic is_special(input op_class_t c);
    return c == op_jump || c == op_fence || c == op_csr_read ||
           c == op_csr_write || c == op_div;
  endfunction

  always_comb begin
    raw_dep  = s0_wren && s0_waddr != '0 &&
               ((s1_rden1 && s1_raddr1 == s0_waddr) ||
                (s1_rden2 && s1_raddr2 == s0_waddr));
    mem_pair = is_mem(s0_class) && is_mem(s1_class);
    special  = is_special(s0_class) || is_special(s1_class);
    pair_ok  = !raw_dep && !mem_pair && !special;
  end

endmodule

`default_nettype wire

//--- rtl/issue_stage.sv
`timescale 1ns/100ps
`default_nettype none

module issue_stage (
  input  logic                             clock,
  input  logic                             reset,
  input  issue_pkg::op_class_t             s0_class,
  input  issue_pkg::op_class_t             s1_class,
  input  logic                             s0_rden1, s0_rden2, s0_wren,
  input  logic                             s1_rden1, s1_rden2, s1_wren,
  input  logic [issue_pkg::reg_addr_w-1:0] s0_raddr1, s0_raddr2, s0_waddr,
  input  logic [issue_pkg::reg_addr_w-1:0] s1_raddr1, s1_raddr2, s1_waddr,
  input  logic [csr_pkg::rm_w-1:0]         s0_rm, s1_rm,
  input  logic [issue_pkg::csr_addr_w-1:0] s0_caddr,
  input  logic                             pair_ok,
  input  issue_pkg::op_class_t             ex_class0, ex_class1,
  input  logic [issue_pkg::reg_addr_w-1:0] ex_waddr0, ex_waddr1,
  input  logic                             mem_csr_write,
  input  logic                             div_busy,
  input  logic                             flush,
  input  csr_pkg::fs_state_t               fs,
  input  logic [csr_pkg::rm_w-1:0]         frm,
  output logic                             stall,
  output logic                             halt,
  output logic                             i0_valid, i1_valid,
  output issue_pkg::op_class_t             i0_class, i1_class,
  output logic [issue_pkg::reg_addr_w-1:0] i0_raddr1, i0_raddr2, i0_waddr,
  output logic [issue_pkg::reg_addr_w-1:0] i1_raddr1, i1_raddr2, i1_waddr,
  output logic [csr_pkg::rm_w-1:0]         i0_rm, i1_rm,
  output logic [issue_pkg::csr_addr_w-1:0] i0_caddr
);
  import issue_pkg::*;
  import csr_pkg::*;

  logic            s0_live, s1_live;
  logic            csr_busy, load_hit, flag_hit;
  op_class_t       s0_cls, s1_cls;
  logic [rm_w-1:0] s0_rm_fix, s1_rm_fix;

  // True when an enabled source matches wa
  function automatic logic reads(input logic en1, input logic [reg_addr_w-1:0] a1,
                                 input logic en2, input logic [reg_addr_w-1:0] a2,
                                 input logic [reg_addr_w-1:0] wa);
    return wa != '0 && ((en1 && a1 == wa) || (en2 && a2 == wa));
  endfunction

  function automatic logic load_dep(input op_class_t c, input logic [reg_addr_w-1:0] wa);
    return c == op_load &&
           (reads(s0_live && s0_rden1, s0_raddr1, s0_live && s0_rden2, s0_raddr2, wa) ||
            reads(s1_live && s1_rden1, s1_raddr1, s1_live && s1_rden2, s1_raddr2, wa));
  endfunction

  assign s0_live = s0_class != op_none;
  assign s1_live = s1_class != op_none;

  always_comb begin
    csr_busy = ex_class0 == op_csr_write || ex_class1 == op_csr_write || mem_csr_write;
    load_hit = load_dep(ex_class0, ex_waddr0) || load_dep(ex_class1, ex_waddr1);
    flag_hit = s0_class == op_csr_read &&
               (s0_caddr == csr_fflags || s0_caddr == csr_fcsr) &&
               (ex_class0 == op_fpu || ex_class1 == op_fpu);
    stall    = !flush && (csr_busy || div_busy || load_hit || flag_hit);
    halt     = !flush && s0_live && s1_live && !pair_ok;
  end

  // FPU off squashes fpu ops, then dynamic rm resolves to frm
  always_comb begin
    s0_cls    = s0_class;
    s1_cls    = s1_class;
    s0_rm_fix = s0_rm;
    s1_rm_fix = s1_rm;
    if (fs == fs_off && s0_class == op_fpu) begin
      s0_cls    = op_none;
      s0_rm_fix = '0;
    end
    if (fs == fs_off && s1_class == op_fpu) begin
      s1_cls    = op_none;
      s1_rm_fix = '0;
    end
    if (s0_rm_fix == rm_dynamic) s0_rm_fix = frm;
    if (s1_rm_fix == rm_dynamic) s1_rm_fix = frm;
  end

  always_ff @(posedge clock) begin
    if (!reset || stall || flush) begin
      i0_valid <= 1'b0;
      i1_valid <= 1'b0;
    end else begin
      i0_valid <= s0_live;
      i1_valid <= s1_live && !halt;  // Halt sends slot 0 alone
    end
  end

  // Disabled sources and destinations go to x0
  always_ff @(posedge clock) begin
    i0_class  <= s0_cls;
    i0_raddr1 <= s0_rden1 ? s0_raddr1 : '0;
    i0_raddr2 <= s0_rden2 ? s0_raddr2 : '0;
    i0_waddr  <= s0_wren ? s0_waddr : '0;
    i0_rm     <= s0_rm_fix;
    i0_caddr  <= s0_caddr;
    i1_class  <= s1_cls;
    i1_raddr1 <= s1_rden1 ? s1_raddr1 : '0;
    i1_raddr2 <= s1_rden2 ? s1_raddr2 : '0;
    i1_waddr  <= s1_wren ? s1_waddr : '0;
    i1_rm     <= s1_rm_fix;
  end

  // Decode must never leave slot 0 empty while slot 1 is filled
  a_slot_order: assert property (@(posedge clock) disable iff (!reset)
    i1_valid |-> i0_valid)
    else $error("i1_valid without i0_valid");

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  logic                             clock,
  input  logic                             reset,
  input  logic [issue_pkg::reg_addr_w-1:0] ra0, ra1, ra2, ra3,
  output logic [issue_pkg::xlen-1:0]       rd0, rd1, rd2, rd3,
  input  logic                             wb_wren0,
  input  logic [issue_pkg::reg_addr_w-1:0] wb_waddr0,
  input  logic [issue_pkg::xlen-1:0]       wb_wdata0,
  input  logic                             wb_wren1,
  input  logic [issue_pkg::reg_addr_w-1:0] wb_waddr1,
  input  logic [issue_pkg::xlen-1:0]       wb_wdata1
);
  import issue_pkg::*;

  logic [xlen-1:0] regs [reg_count];

  // Write-through read with port 1 ahead of port 0
  function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] a);
    if (a == '0) return '0;
    if (wb_wren1 && wb_waddr1 == a) return wb_wdata1;
    if (wb_wren0 && wb_waddr0 == a) return wb_wdata0;
    return regs[a];
  endfunction

  always_comb begin
    rd0 = read_port(ra0);
    rd1 = read_port(ra1);
    rd2 = read_port(ra2);
    rd3 = read_port(ra3);
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wb_wren0 && wb_waddr0 != '0) regs[wb_waddr0] <= wb_wdata0;
      if (wb_wren1 && wb_waddr1 != '0) regs[wb_waddr1] <= wb_wdata1;  // Later one wins
    end
  end

endmodule

`default_nettype wire

//--- rtl/csr_file.sv
`timescale 1ns/100ps
`default_nettype none

module csr_file (
  input  logic                             clock,
  input  logic                             reset,
  input  logic [issue_pkg::csr_addr_w-1:0] craddr,
  input  logic                             csr_wren,
  input  logic [issue_pkg::csr_addr_w-1:0] csr_waddr,
  input  logic [issue_pkg::xlen-1:0]       csr_wdata,
  output logic [issue_pkg::xlen-1:0]       cdata,
  output csr_pkg::fs_state_t               fs,
  output logic [csr_pkg::rm_w-1:0]         frm
);
  import issue_pkg::*;
  import csr_pkg::*;

  fs_state_t           fs_n;
  logic [rm_w-1:0]     frm_n;
  logic [fflags_w-1:0] fflags, fflags_n;
  logic [xlen-1:0]     mscratch, mscratch_n;

  // Next state that also feeds the write-through read
  always_comb begin
    fs_n       = fs;
    frm_n      = frm;
    fflags_n   = fflags;
    mscratch_n = mscratch;
    if (csr_wren) begin
      case (csr_waddr)
        csr_mstatus:  fs_n = fs_state_t'(csr_wdata[fs_lsb +: 2]);
        csr_fflags:   fflags_n = csr_wdata[fflags_w-1:0];
        csr_frm:      frm_n = csr_wdata[rm_w-1:0];
        csr_fcsr: begin
          frm_n    = csr_wdata[fflags_w +: rm_w];
          fflags_n = csr_wdata[fflags_w-1:0];
        end
        csr_mscratch: mscratch_n = csr_wdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (craddr)
      csr_mstatus:  cdata = xlen'(fs_n) << fs_lsb;
      csr_fflags:   cdata = xlen'(fflags_n);
      csr_frm:      cdata = xlen'(frm_n);
      csr_fcsr:     cdata = xlen'({frm_n, fflags_n});
      csr_mscratch: cdata = mscratch_n;
      default:      cdata = '0;  // Unimplemented
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      fs     <= fs_off;
      frm    <= '0;
      fflags <= '0;
    end else begin
      fs     <= fs_n;
      frm    <= frm_n;
      fflags <= fflags_n;
    end
  end

  always_ff @(posedge clock) begin
    mscratch <= mscratch_n;
  end

endmodule

`default_nettype wire

//--- rtl/operand_read.sv
`timescale 1ns/100ps
`default_nettype none

module operand_read (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             flush,
  input  logic                             i0_valid, i1_valid,
  input  issue_pkg::op_class_t             i0_class, i1_class,
  input  logic [issue_pkg::reg_addr_w-1:0] i0_raddr1, i0_raddr2, i0_waddr,
  input  logic [issue_pkg::reg_addr_w-1:0] i1_raddr1, i1_raddr2, i1_waddr,
  input  logic [csr_pkg::rm_w-1:0]         i0_rm, i1_rm,
  input  logic [issue_pkg::csr_addr_w-1:0] i0_caddr,
  output logic [issue_pkg::reg_addr_w-1:0] ra0, ra1, ra2, ra3,
  output logic [issue_pkg::csr_addr_w-1:0] craddr,
  input  logic [issue_pkg::xlen-1:0]       rd0, rd1, rd2, rd3,
  input  logic [issue_pkg::xlen-1:0]       cdata,
  output logic                             x0_valid, x1_valid,
  output issue_pkg::op_class_t             x0_class, x1_class,
  output logic [issue_pkg::reg_addr_w-1:0] x0_waddr, x1_waddr,
  output logic [issue_pkg::xlen-1:0]       x0_rs1, x0_rs2,
  output logic [issue_pkg::xlen-1:0]       x1_rs1, x1_rs2,
  output logic [csr_pkg::rm_w-1:0]         x0_rm, x1_rm,
  output logic [issue_pkg::xlen-1:0]       x0_cdata
);
  import issue_pkg::*;

  logic csr_op;

  // Ports 0/1 serve slot 0, ports 2/3 slot 1
  // Disabled sources arrive as x0 and so read zero
  assign ra0    = i0_raddr1;
  assign ra1    = i0_raddr2;
  assign ra2    = i1_raddr1;
  assign ra3    = i1_raddr2;
  assign craddr = i0_caddr;
  assign csr_op = i0_class == op_csr_read || i0_class == op_csr_write;

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      x0_valid <= 1'b0;
      x1_valid <= 1'b0;
    end else begin
      x0_valid <= i0_valid;
      x1_valid <= i1_valid;
    end
  end

  always_ff @(posedge clock) begin
    x0_class <= i0_class;
    x0_waddr <= i0_waddr;
    x0_rs1   <= rd0;
    x0_rs2   <= rd1;
    x0_rm    <= i0_rm;
    x0_cdata <= csr_op ? cdata : '0;  // Only CSR ops carry CSR data
    x1_class <= i1_class;
    x1_waddr <= i1_waddr;
    x1_rs1   <= rd2;
    x1_rs2   <= rd3;
    x1_rm    <= i1_rm;
  end

endmodule

`default_nettype wire

//--- rtl/issue_top.sv
`timescale 1ns/100ps
`default_nettype none

module issue_top (
  input  logic                             clock,
  input  logic                             reset,
  input  issue_pkg::op_class_t             s0_class, s1_class,
  input  logic                             s0_rden1, s0_rden2, s0_wren,
  input  logic                             s1_rden1, s1_rden2, s1_wren,
  input  logic [issue_pkg::reg_addr_w-1:0] s0_raddr1, s0_raddr2, s0_waddr,
  input  logic [issue_pkg::reg_addr_w-1:0] s1_raddr1, s1_raddr2, s1_waddr,
  input  logic [csr_pkg::rm_w-1:0]         s0_rm, s1_rm,
  input  logic [issue_pkg::csr_addr_w-1:0] s0_caddr,
  input  issue_pkg::op_class_t             ex_class0, ex_class1,
  input  logic [issue_pkg::reg_addr_w-1:0] ex_waddr0, ex_waddr1,
  input  logic                             mem_csr_write,
  input  logic                             div_busy,
  input  logic                             flush,
  input  logic                             wb_wren0, wb_wren1,
  input  logic [issue_pkg::reg_addr_w-1:0] wb_waddr0, wb_waddr1,
  input  logic [issue_pkg::xlen-1:0]       wb_wdata0, wb_wdata1,
  input  logic                             csr_wren,
  input  logic [issue_pkg::csr_addr_w-1:0] csr_waddr,
  input  logic [issue_pkg::xlen-1:0]       csr_wdata,
  output logic                             stall,
  output logic                             halt,
  output logic                             x0_valid, x1_valid,
  output issue_pkg::op_class_t             x0_class, x1_class,
  output logic [issue_pkg::reg_addr_w-1:0] x0_waddr, x1_waddr,
  output logic [issue_pkg::xlen-1:0]       x0_rs1, x0_rs2,
  output logic [issue_pkg::xlen-1:0]       x1_rs1, x1_rs2,
  output logic [csr_pkg::rm_w-1:0]         x0_rm, x1_rm,
  output logic [issue_pkg::xlen-1:0]       x0_cdata
);
  import issue_pkg::*;
  import csr_pkg::*;

  logic                  pair_ok;
  logic                  i0_valid, i1_valid;
  op_class_t             i0_class, i1_class;
  logic [reg_addr_w-1:0] i0_raddr1, i0_raddr2, i0_waddr;
  logic [reg_addr_w-1:0] i1_raddr1, i1_raddr2, i1_waddr;
  logic [rm_w-1:0]       i0_rm, i1_rm;
  logic [csr_addr_w-1:0] i0_caddr;
  logic [reg_addr_w-1:0] ra0, ra1, ra2, ra3;
  logic [xlen-1:0]       rd0, rd1, rd2, rd3;
  logic [csr_addr_w-1:0] craddr;
  logic [xlen-1:0]       cdata;
  fs_state_t             fs;
  logic [rm_w-1:0]       frm;

  // Port names match the nets one for one
  pair_check   u_pair_check   (.*);
  issue_stage  u_issue_stage  (.*);
  reg_file     u_reg_file     (.*);
  csr_file     u_csr_file     (.*);
  operand_read u_operand_read (.*);

endmodule

`default_nettype wire

//--- sim/tb_issue_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_issue_top;
  import issue_pkg::*;
  import csr_pkg::*;

  typedef struct packed {
    logic v;
    op_class_t c;
    logic [4:0] wa;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [2:0] rm;
  } slot_t;

  logic clock = 1'b0;
  logic reset;
  op_class_t s0_class, s1_class, ex_class0, ex_class1;
  logic s0_rden1, s0_rden2, s0_wren, s1_rden1, s1_rden2, s1_wren;
  logic [4:0] s0_raddr1, s0_raddr2, s0_waddr, s1_raddr1, s1_raddr2, s1_waddr;
  logic [2:0] s0_rm, s1_rm;
  logic [11:0] s0_caddr, csr_waddr;
  logic [4:0] ex_waddr0, ex_waddr1, wb_waddr0, wb_waddr1;
  logic mem_csr_write, div_busy, flush, wb_wren0, wb_wren1, csr_wren;
  logic [31:0] wb_wdata0, wb_wdata1, csr_wdata;
  logic stall, halt, x0_valid, x1_valid;
  op_class_t x0_class, x1_class;
  logic [4:0] x0_waddr, x1_waddr;
  logic [31:0] x0_rs1, x0_rs2, x1_rs1, x1_rs2, x0_cdata;
  logic [2:0] x0_rm, x1_rm;

  logic [31:0] model_regs [32];
  logic [1:0] m_fs;
  logic [2:0] m_frm;
  logic [4:0] m_fflags;
  logic [31:0] m_mscratch;
  slot_t exp_i0, exp_i1, exp_x0, exp_x1;
  logic [31:0] exp_ic, exp_xc;
  logic exp_stall, exp_halt;
  logic [31:0] seed = 32'he7fb7c01;
  int cycles = 0;

  issue_top UUT (.*);

  always #4 clock = ~clock;

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Load in execute against any enabled source of a live slot
  function automatic logic load_blocks(input op_class_t c, input logic [4:0] wa);
    logic hit0, hit1;
    hit0 = s0_class != op_none &&
           ((s0_rden1 && s0_raddr1 == wa) || (s0_rden2 && s0_raddr2 == wa));
    hit1 = s1_class != op_none &&
           ((s1_rden1 && s1_raddr1 == wa) || (s1_rden2 && s1_raddr2 == wa));
    return c == op_load && wa != 0 && (hit0 || hit1);
  endfunction

  function automatic logic lone_class(input op_class_t c);
    return c inside {op_jump, op_fence, op_csr_read, op_csr_write, op_div};
  endfunction

  always_comb begin
    exp_stall = !flush && (ex_class0 == op_csr_write || ex_class1 == op_csr_write ||
                mem_csr_write || div_busy || load_blocks(ex_class0, ex_waddr0) ||
                load_blocks(ex_class1, ex_waddr1) ||
                (s0_class == op_csr_read && (s0_caddr == 12'h001 || s0_caddr == 12'h003) &&
                 (ex_class0 == op_fpu || ex_class1 == op_fpu)));
    exp_halt = !flush && s0_class != op_none && s1_class != op_none &&
               ((s0_wren && s0_waddr != 0 && ((s1_rden1 && s1_raddr1 == s0_waddr) ||
                 (s1_rden2 && s1_raddr2 == s0_waddr))) ||
                (s0_class inside {op_load, op_store} && s1_class inside {op_load, op_store}) ||
                lone_class(s0_class) || lone_class(s1_class));
  end

  function automatic logic [31:0] operand(input logic en, input logic [4:0] a);
    return (en && a != 0) ? model_regs[a] : 32'h0;
  endfunction

  function automatic slot_t expect_slot(input logic v, input op_class_t c,
      input logic r1e, input logic [4:0] r1, input logic r2e, input logic [4:0] r2,
      input logic we, input logic [4:0] wa, input logic [2:0] rm);
    slot_t s;
    s.v = v;
    s.c = (c == op_fpu && m_fs == 2'd0) ? op_none : c;
    s.rm = (c == op_fpu && m_fs == 2'd0) ? 3'd0 : (rm == 3'd7 ? m_frm : rm);
    s.wa = we ? wa : 5'd0;
    s.rs1 = operand(r1e, r1);
    s.rs2 = operand(r2e, r2);
    return s;
  endfunction

  function automatic logic [31:0] csr_value(input logic [11:0] a);
    case (a)
      12'h300: return {17'd0, m_fs, 13'd0};
      12'h001: return {27'd0, m_fflags};
      12'h002: return {29'd0, m_frm};
      12'h003: return {24'd0, m_frm, m_fflags};
      12'h340: return m_mscratch;
      default: return 32'h0;
    endcase
  endfunction

  // Expected pipe of issue register and execute bundle
  always @(posedge clock) begin
    if (!reset || flush) begin
      exp_i0.v <= 1'b0;
      exp_i1.v <= 1'b0;
      exp_x0.v <= 1'b0;
      exp_x1.v <= 1'b0;
    end else begin
      exp_x0 <= exp_i0;
      exp_x1 <= exp_i1;
      exp_xc <= exp_ic;
      exp_i0 <= expect_slot(!exp_stall && s0_class != op_none, s0_class, s0_rden1,
                            s0_raddr1, s0_rden2, s0_raddr2, s0_wren, s0_waddr, s0_rm);
      exp_i1 <= expect_slot(!exp_stall && !exp_halt && s1_class != op_none, s1_class,
                            s1_rden1, s1_raddr1, s1_rden2, s1_raddr2, s1_wren, s1_waddr, s1_rm);
      exp_ic <= (s0_class inside {op_csr_read, op_csr_write}) ? csr_value(s0_caddr) : 32'h0;
    end
  end

  task automatic value_fail(input string name, input logic [31:0] got, input logic [31:0] want);
    $display("FAIL %s got %h expected %h", name, got, want);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  a_stall: assert property (@(posedge clock) disable iff (!reset) stall == exp_stall)
    else value_fail("stall", 32'($sampled(stall)), 32'($sampled(exp_stall)));
  a_halt: assert property (@(posedge clock) disable iff (!reset) halt == exp_halt)
    else value_fail("halt", 32'($sampled(halt)), 32'($sampled(exp_halt)));
  a_x0_valid: assert property (@(posedge clock) disable iff (!reset) x0_valid == exp_x0.v)
    else value_fail("x0_valid", 32'($sampled(x0_valid)), 32'($sampled(exp_x0.v)));
  a_x1_valid: assert property (@(posedge clock) disable iff (!reset) x1_valid == exp_x1.v)
    else value_fail("x1_valid", 32'($sampled(x1_valid)), 32'($sampled(exp_x1.v)));
  a_x0_class: assert property (@(posedge clock) disable iff (!reset)
    !x0_valid || x0_class == exp_x0.c)
    else value_fail("x0_class", 32'($sampled(x0_class)), 32'($sampled(exp_x0.c)));
  a_x1_class: assert property (@(posedge clock) disable iff (!reset)
    !x1_valid || x1_class == exp_x1.c)
    else value_fail("x1_class", 32'($sampled(x1_class)), 32'($sampled(exp_x1.c)));
  a_x0_waddr: assert property (@(posedge clock) disable iff (!reset)
    !x0_valid || x0_waddr == exp_x0.wa)
    else value_fail("x0_waddr", 32'($sampled(x0_waddr)), 32'($sampled(exp_x0.wa)));
  a_x1_waddr: assert property (@(posedge clock) disable iff (!reset)
    !x1_valid || x1_waddr == exp_x1.wa)
    else value_fail("x1_waddr", 32'($sampled(x1_waddr)), 32'($sampled(exp_x1.wa)));
  a_x0_rs1: assert property (@(posedge clock) disable iff (!reset)
    !x0_valid || x0_rs1 == exp_x0.rs1)
    else value_fail("x0_rs1", $sampled(x0_rs1), $sampled(exp_x0.rs1));
  a_x0_rs2: assert property (@(posedge clock) disable iff (!reset)
    !x0_valid || x0_rs2 == exp_x0.rs2)
    else value_fail("x0_rs2", $sampled(x0_rs2), $sampled(exp_x0.rs2));
  a_x1_rs1: assert property (@(posedge clock) disable iff (!reset)
    !x1_valid || x1_rs1 == exp_x1.rs1)
    else value_fail("x1_rs1", $sampled(x1_rs1), $sampled(exp_x1.rs1));
  a_x1_rs2: assert property (@(posedge clock) disable iff (!reset)
    !x1_valid || x1_rs2 == exp_x1.rs2)
    else value_fail("x1_rs2", $sampled(x1_rs2), $sampled(exp_x1.rs2));
  a_x0_rm: assert property (@(posedge clock) disable iff (!reset)
    !x0_valid || x0_rm == exp_x0.rm)
    else value_fail("x0_rm", 32'($sampled(x0_rm)), 32'($sampled(exp_x0.rm)));
  a_x1_rm: assert property (@(posedge clock) disable iff (!reset)
    !x1_valid || x1_rm == exp_x1.rm)
    else value_fail("x1_rm", 32'($sampled(x1_rm)), 32'($sampled(exp_x1.rm)));
  a_x0_cdata: assert property (@(posedge clock) disable iff (!reset)
    !x0_valid || x0_cdata == exp_xc)
    else value_fail("x0_cdata", $sampled(x0_cdata), $sampled(exp_xc));

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= 600) begin
      $display("Timeout after 600 cycles");
      $display("STATUS: FAIL");
      $fatal(1);
    end
  end

  task automatic put_slot0(input op_class_t c, input logic r1e, input logic [4:0] r1,
      input logic r2e, input logic [4:0] r2, input logic we, input logic [4:0] wa,
      input logic [2:0] rm);
    s0_class = c;
    s0_rden1 = r1e;
    s0_raddr1 = r1;
    s0_rden2 = r2e;
    s0_raddr2 = r2;
    s0_wren = we;
    s0_waddr = wa;
    s0_rm = rm;
  endtask

  task automatic put_slot1(input op_class_t c, input logic r1e, input logic [4:0] r1,
      input logic r2e, input logic [4:0] r2, input logic we, input logic [4:0] wa,
      input logic [2:0] rm);
    s1_class = c;
    s1_rden1 = r1e;
    s1_raddr1 = r1;
    s1_rden2 = r2e;
    s1_raddr2 = r2;
    s1_wren = we;
    s1_waddr = wa;
    s1_rm = rm;
  endtask

  task automatic idle_cycles(input int n);
    put_slot0(op_none, 0, 0, 0, 0, 0, 0, 0);
    put_slot1(op_none, 0, 0, 0, 0, 0, 0, 0);
    s0_caddr = 0;
    repeat (n) @(negedge clock);
  endtask

  task automatic write_csr(input logic [11:0] a, input logic [31:0] d);
    csr_wren = 1;
    csr_waddr = a;
    csr_wdata = d;
    if (a == 12'h300) m_fs = d[14:13];
    if (a == 12'h002) m_frm = d[2:0];
    if (a == 12'h003) {m_frm, m_fflags} = d[7:0];
    @(negedge clock);
    csr_wren = 0;
    @(negedge clock);
  endtask

  initial begin
    reset = 0;
    flush = 0;
    mem_csr_write = 0;
    div_busy = 0;
    ex_class0 = op_none;
    ex_class1 = op_none;
    ex_waddr0 = 0;
    ex_waddr1 = 0;
    wb_wren0 = 0;
    wb_wren1 = 0;
    wb_waddr0 = 0;
    wb_waddr1 = 0;
    wb_wdata0 = 0;
    wb_wdata1 = 0;
    csr_wren = 0;
    csr_waddr = 0;
    csr_wdata = 0;
    m_fs = 0;
    m_frm = 0;
    m_fflags = 0;
    m_mscratch = 0;
    for (int i = 0; i < 32; i++) model_regs[i] = 0;
    idle_cycles(8);
    reset = 1;
    idle_cycles(3);
    // Fill the register file including a write to x0
    for (int i = 0; i < 32; i++) begin
      seed = lcg(seed);
      wb_wren0 = 1;
      wb_waddr0 = 5'(i);
      wb_wdata0 = seed;
      if (i != 0) model_regs[i] = seed;
      @(negedge clock);
    end
    wb_wren0 = 0;
    for (int k = 0; k < 8; k++) begin
      seed = lcg(seed);
      put_slot0(op_alu, 1, (k == 0) ? 5'd0 : seed[4:0], 1, seed[9:5], 0, 0, seed[30:28]);
      put_slot1(op_alu, 1, seed[14:10], 1, seed[19:15], 1, seed[24:20], seed[27:25]);
      @(negedge clock);
    end
    idle_cycles(3);
    // Dependent pair and then its second half alone
    put_slot0(op_alu, 1, 1, 0, 0, 1, 5, 0);
    put_slot1(op_alu, 1, 5, 1, 2, 1, 6, 0);
    @(negedge clock);
    put_slot0(op_alu, 1, 5, 1, 2, 1, 6, 0);
    put_slot1(op_none, 0, 0, 0, 0, 0, 0, 0);
    @(negedge clock);
    put_slot0(op_load, 1, 3, 0, 0, 1, 8, 0);
    put_slot1(op_load, 1, 4, 0, 0, 1, 9, 0);
    @(negedge clock);
    put_slot0(op_load, 1, 4, 0, 0, 1, 9, 0);
    put_slot1(op_none, 0, 0, 0, 0, 0, 0, 0);
    @(negedge clock);
    idle_cycles(3);
    // Interlocks held for a few cycles each
    put_slot0(op_alu, 1, 7, 1, 2, 1, 10, 0);
    put_slot1(op_alu, 1, 3, 0, 0, 1, 11, 0);
    ex_class0 = op_load;
    ex_waddr0 = 7;
    repeat (3) @(negedge clock);
    ex_class0 = op_none;
    div_busy = 1;
    repeat (2) @(negedge clock);
    div_busy = 0;
    mem_csr_write = 1;
    repeat (2) @(negedge clock);
    mem_csr_write = 0;
    ex_class1 = op_csr_write;
    @(negedge clock);
    ex_class1 = op_none;
    @(negedge clock);
    idle_cycles(3);
    // FPU off and then on with dynamic rounding
    put_slot0(op_fpu, 1, 1, 1, 2, 1, 12, 3'd7);
    @(negedge clock);
    idle_cycles(3);
    write_csr(12'h300, 32'h0000_6000);
    write_csr(12'h002, 32'h3);
    put_slot0(op_fpu, 1, 1, 1, 2, 1, 12, 3'd7);
    @(negedge clock);
    idle_cycles(2);
    write_csr(12'h003, 32'h0000_0075);
    put_slot0(op_csr_read, 0, 0, 0, 0, 1, 13, 0);
    s0_caddr = 12'h003;
    ex_class1 = op_fpu;  // Flags of an fpu op still pending
    @(negedge clock);
    ex_class1 = op_none;
    @(negedge clock);
    idle_cycles(3);
    // Flush with a pair in the issue register
    put_slot0(op_alu, 1, 1, 1, 2, 1, 14, 0);
    put_slot1(op_alu, 1, 3, 1, 4, 1, 15, 0);
    @(negedge clock);
    idle_cycles(0);
    flush = 1;
    @(negedge clock);
    flush = 0;
    idle_cycles(4);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
rtl/issue_pkg.sv
rtl/csr_pkg.sv
rtl/pair_check.sv
rtl/issue_stage.sv
rtl/reg_file.sv
rtl/csr_file.sv
rtl/operand_read.sv
rtl/issue_top.sv
sim/tb_issue_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the issue stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_issue_top -f src.f -o sim_issue

output=$(./obj_dir/sim_issue)
echo "$output"

if echo "$output" | grep -qx "STATUS: PASS"; then
  exit 0
else
  exit 1
fi
